// File: sim.f
+incdir+hw
hw/ieu_pkg.sv
hw/ieu_id.sv
hw/ieu_ex.sv
hw/ieu_cdb_buf.sv
hw/ieu.sv
sim/tb_clk_gen.sv
sim/tb_ieu.sv

// File: Makefile
# Verilator simulation of the integer execution unit testbench
# Usage: make sim, make clean; variables may be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ieu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -x -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_ieu.sv
// Testbench for the integer execution unit
// Table-driven issue with reservation station and CDB arbiter models around the DUT

`include "ieu_cfg.svh"

module tb_ieu;

    timeunit 1ns;
    timeprecision 1ps;

    import types::*;

    localparam int SAMPLE_DELAY = 20;
    localparam int RUN_TIMEOUT  = 2000;
    localparam int RST_TIMEOUT  = 40;
    localparam int LATENCY      = 3;
    // JALR row that is issued again after the flush
    localparam int AFTER_FLUSH_ROW = 31;

    logic    clk;
    logic    n_rst;
    logic    flush;
    logic    grant;
    logic    credit;
    fu_req_t fu;
    cdb_t    cdb;

    string   row_name[$];
    fu_req_t row_req[$];
    cdb_t    row_exp[$];

    // Results in flight in issue order
    string   pend_name[$];
    cdb_t    pend_exp[$];
    int      pend_cycle[$];

    int   credits;
    int   cycle_no;
    logic check_lat;
    int   err_result;
    int   err_credit;
    int   err_timing;
    int   err_other;

    tb_clk_gen clk_gen0 (
        .clk   (clk),
        .n_rst (n_rst)
    );

    ieu dut0 (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (flush),
        .i_fu        (fu),
        .o_fu_credit (credit),
        .o_cdb       (cdb),
        .i_cdb_grant (grant)
    );

    // RV32I instruction word builders with fixed register fields
    function automatic logic [31:0] r_type(input int f7, input int f3);
        return {f7[6:0], 5'd2, 5'd1, f3[2:0], 5'd3, OP};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int f3, input opcode_t op);
        return {imm[11:0], 5'd1, f3[2:0], 5'd3, op};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input opcode_t op);
        return {imm[19:0], 5'd3, op};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3[2:0], imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, JAL};
    endfunction

    task automatic add_row(input string name, input opcode_t op, input logic [31:0] insn,
                           input logic [31:0] iaddr, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] data,
                           input logic [31:0] addr, input int redir);
        fu_req_t req;
        cdb_t    exp;
        req          = '0;
        req.valid    = 1'b1;
        req.opcode   = op;
        req.iaddr    = iaddr;
        req.insn     = insn;
        req.src_a    = a;
        req.src_b    = b;
        req.tag      = `TAG_WIDTH'(row_req.size());
        exp.data     = data;
        exp.addr     = addr;
        exp.tag      = req.tag;
        exp.redirect = (redir != 0);
        exp.en       = 1'b1;
        row_name.push_back(name);
        row_req.push_back(req);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        // name, opcode, insn, iaddr, src_a, src_b, exp data, exp addr, exp redirect
        add_row("add", OP, r_type(0, 0), 'h100, 5, 7, 12, 'h104, 0);
        add_row("sub", OP, r_type('h20, 0), 'h104, 5, 7, 'hfffffffe, 'h108, 0);
        add_row("xor", OP, r_type(0, 4), 'h108, 'hf0f000ff, 'h0ff00f0f, 'hff000ff0, 'h10c, 0);
        add_row("or", OP, r_type(0, 6), 'h10c, 'h12000034, 'h00567800, 'h12567834, 'h110, 0);
        add_row("and", OP, r_type(0, 7), 'h110, 'hffff0f0f, 'h12345678, 'h12340608, 'h114, 0);
        add_row("slt", OP, r_type(0, 2), 'h114, 'hffffffff, 1, 1, 'h118, 0);
        add_row("sltu", OP, r_type(0, 3), 'h118, 'hffffffff, 1, 0, 'h11c, 0);
        add_row("sll", OP, r_type(0, 1), 'h11c, 3, 'h24, 'h30, 'h120, 0);
        add_row("srl", OP, r_type(0, 5), 'h120, 'h80000000, 4, 'h08000000, 'h124, 0);
        add_row("sra_neg", OP, r_type('h20, 5), 'h124, 'h80000000, 4, 'hf8000000, 'h128, 0);
        add_row("addi", OP_IMM, i_type(-1, 0, OP_IMM), 'h128, 10, 'hdeadbeef, 9, 'h12c, 0);
        add_row("slti", OP_IMM, i_type(-2048, 2, OP_IMM), 'h12c, 'hfffff000, 0, 1, 'h130, 0);
        add_row("sltiu", OP_IMM, i_type(-1, 3, OP_IMM), 'h130, 5, 0, 1, 'h134, 0);
        add_row("srai", OP_IMM, i_type('h408, 5, OP_IMM), 'h134, 'h87654321, 0, 'hff876543,
                'h138, 0);
        add_row("slli", OP_IMM, i_type(31, 1, OP_IMM), 'h138, 1, 0, 'h80000000, 'h13c, 0);
        add_row("lui", LUI, u_type('habcde, LUI), 'h13c, 'h55, 'h66, 'habcde000, 'h140, 0);
        add_row("auipc", AUIPC, u_type('h10, AUIPC), 'h140, 0, 0, 'h10140, 'h144, 0);
        add_row("beq_t", BRANCH, b_type(16, 0), 'h200, 7, 7, 0, 'h210, 1);
        add_row("beq_nt", BRANCH, b_type(16, 0), 'h204, 7, 8, 0, 'h208, 0);
        add_row("bne_t", BRANCH, b_type(-8, 1), 'h208, 1, 2, 0, 'h200, 1);
        add_row("bne_nt", BRANCH, b_type(-8, 1), 'h20c, 3, 3, 0, 'h210, 0);
        add_row("blt_t", BRANCH, b_type(32, 4), 'h210, 'h80000000, 'h7fffffff, 0, 'h230, 1);
        add_row("blt_nt", BRANCH, b_type(32, 4), 'h214, 'h7fffffff, 'h80000000, 0, 'h218, 0);
        add_row("bge_t", BRANCH, b_type(64, 5), 'h218, 'hffffffff, 'hffffffff, 0, 'h258, 1);
        add_row("bge_nt", BRANCH, b_type(64, 5), 'h21c, 'hfffffffe, 'hffffffff, 0, 'h220, 0);
        add_row("bltu_t", BRANCH, b_type(-16, 6), 'h220, 'h7fffffff, 'h80000000, 0, 'h210, 1);
        add_row("bltu_nt", BRANCH, b_type(-16, 6), 'h224, 'hffffffff, 0, 0, 'h228, 0);
        add_row("bgeu_t", BRANCH, b_type(12, 7), 'h228, 'h80000000, 'h7fffffff, 0, 'h234, 1);
        add_row("bgeu_nt", BRANCH, b_type(12, 7), 'h22c, 0, 1, 0, 'h230, 0);
        add_row("jal", JAL, j_type(2048), 'h300, 0, 0, 'h304, 'hb00, 1);
        add_row("jal_back", JAL, j_type(-256), 'h400, 0, 0, 'h404, 'h300, 1);
        add_row("jalr", JALR, i_type(17, 0, JALR), 'h500, 'h1000, 0, 'h504, 'h1010, 1);
        add_row("jalr_neg", JALR, i_type(-4, 0, JALR), 'h504, 'h2001, 0, 'h508, 'h1ffc, 1);
    endtask

    task automatic check_cdb(input string name, input cdb_t exp, input cdb_t got);
        if (got !== exp) begin
            err_result++;
            $display("FAILED %s: expected data=%h addr=%h tag=%0d redirect=%b",
                     name, exp.data, exp.addr, exp.tag, exp.redirect,
                     ", actual data=%h addr=%h tag=%0d redirect=%b",
                     got.data, got.addr, got.tag, got.redirect);
        end
    endtask

    task automatic check_credits(input string name, input int exp, input int got);
        if (got != exp) begin
            err_credit++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, got);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int got);
        if (got != exp) begin
            err_timing++;
            $display("FAILED %s latency: expected %0d cycles, actual %0d", name, exp, got);
        end
    endtask

    // Drive on the falling edge and sample in the low phase
    task automatic step(input logic issue, input int row, input logic g, input logic f);
        logic accept;
        @(negedge clk);
        cycle_no++;
        fu = '0;
        if (issue) begin
            fu = row_req[row];
            credits--;
            pend_name.push_back(row_name[row]);
            pend_exp.push_back(row_exp[row]);
            pend_cycle.push_back(cycle_no);
        end
        grant = g;
        flush = f;
        #(SAMPLE_DELAY);
        accept = cdb.en && grant && !flush;
        check_credits("credit pulse", int'(accept), int'(credit));
        if (accept) begin
            if (pend_exp.size() == 0) begin
                err_other++;
                $display("ERROR: CDB result accepted with nothing in flight, cycle %0d",
                         cycle_no);
            end else begin
                check_cdb(pend_name[0], pend_exp[0], cdb);
                if (check_lat) begin
                    check_latency(pend_name[0], LATENCY, cycle_no - pend_cycle[0]);
                end
                void'(pend_name.pop_front());
                void'(pend_exp.pop_front());
                void'(pend_cycle.pop_front());
            end
        end
        if (credit === 1'b1) begin
            credits++;
        end
        if (credits < 0 || credits > `IEU_CREDITS) begin
            err_credit++;
            $display("ERROR: issuer credit count %0d out of range, cycle %0d",
                     credits, cycle_no);
        end
        // Everything in flight is dropped and the issuer starts over with full credits
        if (f) begin
            pend_name.delete();
            pend_exp.delete();
            pend_cycle.delete();
            credits = `IEU_CREDITS;
        end
    endtask

    task automatic wait_reset();
        int guard;
        guard = 0;
        while (n_rst !== 1'b1 && guard < RST_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (n_rst !== 1'b1) begin
            err_other++;
            $display("ERROR: timeout waiting for reset release");
        end
    endtask

    task automatic run_table(input int grant_pct);
        int   row;
        int   guard;
        logic issue;
        logic g;
        row   = 0;
        guard = 0;
        while ((row < row_req.size() || pend_exp.size() != 0) && guard < RUN_TIMEOUT) begin
            issue = (row < row_req.size()) && (credits > 0);
            g     = ($urandom_range(99) < grant_pct);
            step(issue, row, g, 1'b0);
            if (issue) begin
                row++;
            end
            guard++;
        end
        if (row < row_req.size() || pend_exp.size() != 0) begin
            err_other++;
            $display("ERROR: timeout with %0d rows unissued and %0d results outstanding",
                     row_req.size() - row, pend_exp.size());
        end
    endtask

    task automatic flush_test();
        int guard;
        // Fill buffer, EX and ID with grant held low
        for (int i = 0; i < 3; i++) begin
            step(1'b1, i, 1'b0, 1'b0);
        end
        step(1'b0, 0, 1'b1, 1'b1);
        for (int i = 0; i < 6; i++) begin
            step(1'b0, 0, 1'b1, 1'b0);
            if (cdb.en !== 1'b0) begin
                err_other++;
                $display("ERROR: CDB enable high for a flushed instruction, cycle %0d",
                         cycle_no);
            end
        end
        step(1'b1, AFTER_FLUSH_ROW, 1'b1, 1'b0);
        guard = 0;
        while (pend_exp.size() != 0 && guard < RUN_TIMEOUT) begin
            step(1'b0, 0, 1'b1, 1'b0);
            guard++;
        end
        if (pend_exp.size() != 0) begin
            err_other++;
            $display("ERROR: timeout waiting for the result issued after flush");
        end
    endtask

    initial begin
        fu         = '0;
        grant      = 1'b0;
        flush      = 1'b0;
        credits    = `IEU_CREDITS;
        cycle_no   = 0;
        check_lat  = 1'b0;
        err_result = 0;
        err_credit = 0;
        err_timing = 0;
        err_other  = 0;
        void'($urandom(34));
        build_table();
        wait_reset();
        if (cdb.en !== 1'b0 || credit !== 1'b0) begin
            err_other++;
            $display("ERROR: CDB enable or credit not low after reset");
        end

        check_lat = 1'b1;
        run_table(100);
        check_credits("credits after full grant run", `IEU_CREDITS, credits);

        check_lat = 1'b0;
        run_table(40);
        check_credits("credits after random grant run", `IEU_CREDITS, credits);

        check_lat = 1'b1;
        flush_test();
        check_credits("credits at end", `IEU_CREDITS, credits);

        $display("Errors: result %0d, credit %0d, timing %0d, other %0d",
                 err_result, err_credit, err_timing, err_other);
        if (err_result + err_credit + err_timing + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim/tb_clk_gen.sv
// Clock and reset source for the execution unit testbench
// 100 ns clock, active-low reset held for the first 16 cycles

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic n_rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released in the high phase, away from both edges
    initial begin
        n_rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #(PERIOD / 4);
        n_rst = 1'b1;
    end

endmodule

// File: hw/ieu.sv
// Integer execution unit top level
// ID -> EX -> result buffer pipeline with credit-based issue and flush

`include "ieu_cfg.svh"

module ieu (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           i_flush,
    input  types::fu_req_t i_fu,
    output logic           o_fu_credit,
    output types::cdb_t    o_cdb,
    input  logic           i_cdb_grant
);

    import types::*;

    ieu_id_t id_d;
    ieu_id_t id_data_q;
    logic    id_valid_q;
    ieu_id_t id_q;

    ieu_ex_t ex_d;
    ieu_ex_t ex_data_q;
    logic    ex_valid_q;
    ieu_ex_t ex_q;

    // Valid bits cleared on reset or flush
    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else if (i_flush) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            id_valid_q <= id_d.valid;
            ex_valid_q <= id_q.valid;
        end
    end

    // Payloads
    always_ff @(posedge clk) begin
        id_data_q <= id_d;
        ex_data_q <= ex_d;
    end

    always_comb begin
        id_q       = id_data_q;
        id_q.valid = id_valid_q;
        ex_q       = ex_data_q;
        ex_q.valid = ex_valid_q;
    end

    ieu_id ieu_id_inst (
        .clk   (clk),
        .n_rst (n_rst),
        .i_req (i_fu),
        .o_id  (id_d)
    );

    ieu_ex ieu_ex_inst (
        .clk   (clk),
        .n_rst (n_rst),
        .i_id  (id_q),
        .o_ex  (ex_d)
    );

    ieu_cdb_buf ieu_cdb_buf_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (i_flush),
        .i_ex        (ex_q),
        .i_cdb_grant (i_cdb_grant),
        .o_cdb       (o_cdb),
        .o_fu_credit (o_fu_credit)
    );

endmodule

// File: hw/ieu_cdb_buf.sv
// Result buffer between EX and the common data bus
// Holds results in order until granted; each pop returns one issue credit

`include "ieu_cfg.svh"

module ieu_cdb_buf (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           i_flush,
    input  types::ieu_ex_t i_ex,
    input  logic           i_cdb_grant,
    output types::cdb_t    o_cdb,
    output logic           o_fu_credit
);

    import types::*;

    localparam int DEPTH = `IEU_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ieu_ex_t          mem [DEPTH];
    ieu_ex_t          head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             not_empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Flush wins over both write and grant
    assign push        = i_ex.valid & ~i_flush;
    assign pop         = not_empty & i_cdb_grant & ~i_flush;
    assign o_fu_credit = pop;

    always_comb begin
        o_cdb.data     = head.data;
        o_cdb.addr     = head.addr;
        o_cdb.tag      = head.tag;
        o_cdb.redirect = head.redirect;
        o_cdb.en       = not_empty;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_ex;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/ieu_ex.sv
// Execute stage of the integer execution unit
// ALU, branch comparator and target adder that form the result record

`include "ieu_cfg.svh"

module ieu_ex (
    input  logic           clk,
    input  logic           n_rst,
    input  types::ieu_id_t i_id,
    output types::ieu_ex_t o_ex
);

    import types::*;

    logic [`DATA_WIDTH-1:0] alu_res;
    logic                   eq;
    logic                   lt;
    logic                   ltu;
    logic                   cond;
    logic                   taken;
    logic                   redirect;
    logic                   is_jalr;
    logic [`ADDR_WIDTH-1:0] pc_next;
    logic [`ADDR_WIDTH-1:0] jmp_base;
    logic [`ADDR_WIDTH-1:0] target_sum;
    logic [`ADDR_WIDTH-1:0] target;

    // One comparator serves SLT/SLTU and the branches
    assign eq  = (i_id.src_a == i_id.src_b);
    assign lt  = ($signed(i_id.src_a) < $signed(i_id.src_b));
    assign ltu = (i_id.src_a < i_id.src_b);

    always_comb begin
        case (i_id.alu_func)
            ALU_ADD:  alu_res = i_id.src_a + i_id.src_b;
            ALU_SUB:  alu_res = i_id.src_a - i_id.src_b;
            ALU_SLL:  alu_res = i_id.src_a << i_id.shamt;
            ALU_SLT:  alu_res = `DATA_WIDTH'(lt);
            ALU_SLTU: alu_res = `DATA_WIDTH'(ltu);
            ALU_XOR:  alu_res = i_id.src_a ^ i_id.src_b;
            ALU_SRL:  alu_res = i_id.src_a >> i_id.shamt;
            ALU_SRA:  alu_res = $signed(i_id.src_a) >>> i_id.shamt;
            ALU_OR:   alu_res = i_id.src_a | i_id.src_b;
            ALU_AND:  alu_res = i_id.src_a & i_id.src_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (i_id.alu_func)
            ALU_BEQ:  cond = eq;
            ALU_BNE:  cond = ~eq;
            ALU_BLT:  cond = lt;
            ALU_BGE:  cond = ~lt;
            ALU_BLTU: cond = ltu;
            ALU_BGEU: cond = ~ltu;
            default:  cond = 1'b0;
        endcase
    end

    assign taken    = i_id.br & cond;
    assign redirect = i_id.jmp | taken;

    // Target adder with a register base for JALR
    assign is_jalr    = (i_id.alu_func == ALU_JALR);
    assign jmp_base   = is_jalr ? `ADDR_WIDTH'(i_id.src_a) : i_id.iaddr;
    assign target_sum = jmp_base + `ADDR_WIDTH'(i_id.imm_b);
    assign target     = {target_sum[`ADDR_WIDTH-1:1], target_sum[0] & ~is_jalr};

    assign pc_next = i_id.iaddr + `ADDR_WIDTH'(4);

    always_comb begin
        o_ex.tag      = i_id.tag;
        o_ex.valid    = i_id.valid;
        o_ex.redirect = redirect;
        o_ex.addr     = redirect ? target : pc_next;

        // Jumps write the link address and branches write zero
        if (i_id.jmp) begin
            o_ex.data = `DATA_WIDTH'(pc_next);
        end else if (i_id.br) begin
            o_ex.data = '0;
        end else begin
            o_ex.data = alu_res;
        end
    end

endmodule

// File: hw/ieu_id.sv
// Decode stage of the integer execution unit
// Combinational decode of an issue request into the record for the ID -> EX register

`include "ieu_cfg.svh"

module ieu_id (
    input  logic           clk,
    input  logic           n_rst,
    input  types::fu_req_t i_req,
    output types::ieu_id_t o_id
);

    import types::*;

    logic [2:0]             funct3;
    logic                   funct7_b5;
    logic [`DATA_WIDTH-1:0] imm_i;
    logic [`DATA_WIDTH-1:0] imm_u;
    logic [`DATA_WIDTH-1:0] imm_br;
    logic [`DATA_WIDTH-1:0] imm_j;

    // funct3 decode shared by OP and OP_IMM
    // SUB only exists in the register form
    function automatic alu_func_t arith_func(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        alu_func_t func;
        case (f3)
            3'b000:  func = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  func = ALU_SLL;
            3'b010:  func = ALU_SLT;
            3'b011:  func = ALU_SLTU;
            3'b100:  func = ALU_XOR;
            3'b101:  func = alt ? ALU_SRA : ALU_SRL;
            3'b110:  func = ALU_OR;
            default: func = ALU_AND;
        endcase
        return func;
    endfunction

    function automatic alu_func_t branch_func(input logic [2:0] f3);
        alu_func_t func;
        case (f3)
            3'b000:  func = ALU_BEQ;
            3'b001:  func = ALU_BNE;
            3'b100:  func = ALU_BLT;
            3'b101:  func = ALU_BGE;
            3'b110:  func = ALU_BLTU;
            default: func = ALU_BGEU;
        endcase
        return func;
    endfunction

    assign funct3    = i_req.insn[14:12];
    assign funct7_b5 = i_req.insn[30];

    // Immediate formats, all sign extended
    assign imm_i  = {{(`DATA_WIDTH-12){i_req.insn[31]}}, i_req.insn[31:20]};
    assign imm_u  = {{(`DATA_WIDTH-32){i_req.insn[31]}}, i_req.insn[31:12], 12'b0};
    assign imm_br = {{(`DATA_WIDTH-13){i_req.insn[31]}}, i_req.insn[31], i_req.insn[7],
                     i_req.insn[30:25], i_req.insn[11:8], 1'b0};
    assign imm_j  = {{(`DATA_WIDTH-21){i_req.insn[31]}}, i_req.insn[31], i_req.insn[19:12],
                     i_req.insn[20], i_req.insn[30:21], 1'b0};

    always_comb begin
        o_id          = '0;
        o_id.alu_func = ALU_ADD;
        o_id.src_a    = i_req.src_a;
        o_id.src_b    = i_req.src_b;
        o_id.iaddr    = i_req.iaddr;
        o_id.shamt    = i_req.src_b[4:0];
        o_id.tag      = i_req.tag;
        o_id.valid    = i_req.valid;

        case (i_req.opcode)
            OP: begin
                o_id.alu_func = arith_func(funct3, funct7_b5, 1'b1);
            end
            OP_IMM: begin
                o_id.alu_func = arith_func(funct3, funct7_b5, 1'b0);
                o_id.src_b    = imm_i;
                o_id.shamt    = i_req.insn[24:20];
            end
            LUI: begin
                o_id.src_a = '0;
                o_id.src_b = imm_u;
            end
            AUIPC: begin
                o_id.src_a = `DATA_WIDTH'(i_req.iaddr);
                o_id.src_b = imm_u;
            end
            JAL: begin
                o_id.alu_func = ALU_JAL;
                o_id.imm_b    = imm_j;
                o_id.jmp      = 1'b1;
            end
            JALR: begin
                o_id.alu_func = ALU_JALR;
                o_id.imm_b    = imm_i;
                o_id.jmp      = 1'b1;
            end
            BRANCH: begin
                o_id.alu_func = branch_func(funct3);
                o_id.imm_b    = imm_br;
                o_id.br       = 1'b1;
            end
            default: begin
                o_id.alu_func = ALU_ADD;
            end
        endcase
    end

endmodule

// File: hw/ieu_pkg.sv
// Types shared by the integer execution unit stages
// Holds the RV32I opcode and ALU function enums and the stage records

`include "ieu_cfg.svh"

package types;

    // RV32I major opcodes handled by this unit
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_t;

    // Operation chosen by ID for EX
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JAL,
        ALU_JALR
    } alu_func_t;

    // Issue request from the reservation station
    typedef struct packed {
        logic                   valid;
        opcode_t                opcode;
        logic [`ADDR_WIDTH-1:0] iaddr;
        logic [31:0]            insn;
        logic [`DATA_WIDTH-1:0] src_a;
        logic [`DATA_WIDTH-1:0] src_b;
        logic [`TAG_WIDTH-1:0]  tag;
    } fu_req_t;

    // ID -> EX record
    typedef struct packed {
        alu_func_t              alu_func;
        logic [`DATA_WIDTH-1:0] src_a;
        logic [`DATA_WIDTH-1:0] src_b;
        logic [`ADDR_WIDTH-1:0] iaddr;
        logic [`DATA_WIDTH-1:0] imm_b;
        logic [4:0]             shamt;
        logic [`TAG_WIDTH-1:0]  tag;
        logic                   jmp;
        logic                   br;
        logic                   valid;
    } ieu_id_t;

    // EX result record
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`TAG_WIDTH-1:0]  tag;
        logic                   redirect;
        logic                   valid;
    } ieu_ex_t;

    // Common data bus broadcast
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`TAG_WIDTH-1:0]  tag;
        logic                   redirect;
        logic                   en;
    } cdb_t;

endpackage

// File: hw/ieu_cfg.svh
// Widths and credit count of the integer execution unit
// Included by the types package and by every RTL module of the unit

`ifndef IEU_CFG_SVH
`define IEU_CFG_SVH

// Operand and result width
`define DATA_WIDTH 32

// Instruction address width
`define ADDR_WIDTH 32

// Reservation station / ROB tag width
`define TAG_WIDTH 6

// Issue credits held by the reservation station
// Also the depth of the result buffer
`define IEU_CREDITS 4

`endif
